/* tb.f */
+incdir+logic
logic/lsu_pkg.sv
logic/lsu_mem2reg.sv
logic/lsu_reg2mem.sv
logic/lsu_dmem.sv
logic/lsu_ctrl.sv
logic/lsu_top.sv
sim/lsu_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= lsu_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

PASS_MSG := Simulation completed successfully

SRCS    := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS    := $(wildcard logic/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/lsu_tb.sv */
`timescale 1ns/100ps

`include "lsu_settings.svh"

module lsu_tb
	import lsu_pkg::*;
();

	localparam int BAW     = `LSU_MEM_AW + 2;	// byte address bits inside the memory
	localparam int TIMEOUT = 20;	// cycles allowed for a done pulse

	typedef logic [BAW-1:0] baddr_t;

	logic     clk;
	logic     rst;
	logic     req;
	lsu_req_t req_data;
	logic     done;
	lsu_rsp_t rsp;

	logic [7:0]  ref_mem [2**BAW];	// byte model of big endian words
	logic [15:0] lfsr_state;
	int          error_count;
	int          check_count;
	int          test_count;
	logic [31:0] stream_rdata_q [$];	// expected stream responses in order
	logic        stream_err_q [$];

	lsu_top i_lsu_top (
		.clk      (clk),
		.rst      (rst),
		.req      (req),
		.req_data (req_data),
		.done     (done),
		.rsp      (rsp)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;	// 100 ns period
	end

	// fibonacci lfsr with taps 16 14 13 11 and one step per bit
	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
			lfsr_state = {lfsr_state[14:0], fb};
			r          = {r[30:0], fb};
		end
		return r;
	endfunction

	function automatic lsu_op_e pick_op(input logic [2:0] sel);
		case (sel)
			3'd0: return lbz;
			3'd1: return lbs;
			3'd2: return lhz;
			3'd3: return lhs;
			3'd4: return lwz;
			3'd5: return sb;
			3'd6: return sh;
			default: return sw;
		endcase
	endfunction

	// every byte depends on the whole word index
	function automatic logic [31:0] fill_word(input logic [7:0] w);
		return {~w, w ^ 8'h3c, w + 8'h71, {w[3:0], w[7:4]}};
	endfunction

	// big endian so the lowest byte address is the top of the word
	function automatic logic [31:0] load_model(input lsu_op_e op, input logic [31:0] addr);
		baddr_t      a;
		logic [7:0]  b;
		logic [15:0] h;
		logic [31:0] w;
		a = addr[BAW-1:0];	// upper bits alias
		b = ref_mem[a];
		h = {ref_mem[{a[BAW-1:1], 1'b0}], ref_mem[{a[BAW-1:1], 1'b1}]};
		w = {ref_mem[{a[BAW-1:2], 2'd0}], ref_mem[{a[BAW-1:2], 2'd1}],
			ref_mem[{a[BAW-1:2], 2'd2}], ref_mem[{a[BAW-1:2], 2'd3}]};
		case (op)
			lbz: return {24'h0, b};
			lbs: return {{24{b[7]}}, b};
			lhz: return {16'h0, h};
			lhs: return {{16{h[15]}}, h};
			default: return w;
		endcase
	endfunction

	task automatic store_model(input lsu_op_e op, input logic [31:0] addr,
		input logic [31:0] data);
		baddr_t a;
		a = addr[BAW-1:0];
		if (op == sb) begin
			ref_mem[a] = data[7:0];
		end else if (op == sh) begin
			ref_mem[{a[BAW-1:1], 1'b0}] = data[15:8];	// high half first
			ref_mem[{a[BAW-1:1], 1'b1}] = data[7:0];
		end else if (op == sw) begin
			ref_mem[{a[BAW-1:2], 2'd0}] = data[31:24];
			ref_mem[{a[BAW-1:2], 2'd1}] = data[23:16];
			ref_mem[{a[BAW-1:2], 2'd2}] = data[15:8];
			ref_mem[{a[BAW-1:2], 2'd3}] = data[7:0];
		end
	endtask

	// expected response and model update for aligned stores
	task automatic expected_response(input lsu_op_e op, input logic [31:0] addr,
		input logic [31:0] data, output logic [31:0] exp_rdata, output logic exp_err);
		logic is_half;
		logic is_word;
		is_half   = (op == lhz) || (op == lhs) || (op == sh);
		is_word   = (op == lwz) || (op == sw);
		exp_err   = (is_half && addr[0]) || (is_word && addr[1:0] != 2'b00);
		exp_rdata = '0;	// stores, nop and errors
		if (!exp_err) begin
			if (op == sb || op == sh || op == sw) begin
				store_model(op, addr, data);
			end else if (op != nop) begin
				exp_rdata = load_model(op, addr);
			end
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("ERROR %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic wait_for_done(input string name, output bit seen);
		int cycles;
		seen   = 1'b0;
		cycles = 0;
		while (!seen && cycles < TIMEOUT) begin
			@(negedge clk);	// outputs settled mid cycle
			cycles++;
			seen = (done === 1'b1);
		end
		if (!seen) begin
			error_count++;
			$display("%s: no done pulse within %0d cycles", name, TIMEOUT);
		end
	endtask

	// one request with its response checked against the model
	task automatic run_access(input string name, input lsu_op_e op, input logic [31:0] addr,
		input logic [31:0] data, output logic [31:0] rdata);
		logic [31:0] exp_rdata;
		logic        exp_err;
		bit          seen;
		expected_response(op, addr, data, exp_rdata, exp_err);
		@(posedge clk);
		req      <= 1'b1;
		req_data <= '{op, addr, data};
		@(posedge clk);	// sampled here
		req      <= 1'b0;
		wait_for_done(name, seen);
		rdata = rsp.rdata;
		if (seen) begin
			check_value(name, exp_rdata, rsp.rdata);
			check_value(name, {31'h0, exp_err}, {31'h0, rsp.align_err});
		end
	endtask

	task automatic finish_test(input string name, input int errors_before);
		test_count++;
		if (error_count == errors_before) begin
			$display("%s: pass", name);
		end else begin
			$display("%s: %0d errors", name, error_count - errors_before);
		end
	endtask

	task automatic preload_memory();
		logic [31:0] rdata;
		logic [7:0]  w;
		for (int i = 0; i < `LSU_MEM_WORDS; i++) begin
			w = 8'(i);
			run_access("preload_memory", sw, 32'(i * 4), fill_word(w), rdata);
		end
	endtask

	task automatic reset_values();
		int errs;
		errs = error_count;
		@(negedge clk);
		check_value("reset_values", 32'h0, {31'h0, done});
		check_value("reset_values", 32'h0, {31'h0, rsp.align_err});
		finish_test("reset_values", errs);
	endtask

	task automatic word_round_trip();
		int          errs;
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] rdata;
		errs = error_count;
		for (int i = 0; i < 8; i++) begin
			addr      = lfsr_bits(32);
			addr[1:0] = 2'b00;	// random upper bits alias
			data      = lfsr_bits(32);
			run_access("word_round_trip", sw, addr, data, rdata);
			run_access("word_round_trip", lwz, addr, 32'h0, rdata);
			check_value("word_round_trip", data, rdata);
		end
		finish_test("word_round_trip", errs);
	endtask

	task automatic byte_loads();
		int          errs;
		logic [31:0] word;
		logic [31:0] base;
		logic [31:0] rdata;
		logic [7:0]  b;
		errs = error_count;
		for (int w = 0; w < 2; w++) begin
			word      = (w == 0) ? 32'h8a7f01f3 : 32'h7c93e512;	// msb set and clear mixed
			base      = lfsr_bits(32);
			base[1:0] = 2'b00;
			run_access("byte_loads", sw, base, word, rdata);
			for (int off = 0; off < 4; off++) begin
				b = 8'(word >> (24 - 8 * off));	// offset 0 is the top byte
				run_access("byte_loads", lbz, base + 32'(off), 32'h0, rdata);
				check_value("byte_loads", {24'h0, b}, rdata);
				run_access("byte_loads", lbs, base + 32'(off), 32'h0, rdata);
				check_value("byte_loads", {{24{b[7]}}, b}, rdata);
			end
		end
		finish_test("byte_loads", errs);
	endtask

	task automatic halfword_loads();
		int          errs;
		logic [31:0] base;
		logic [31:0] rdata;
		logic [15:0] h;
		errs      = error_count;
		base      = lfsr_bits(32);
		base[1:0] = 2'b00;
		run_access("halfword_loads", sw, base, 32'hf00d7ab3, rdata);
		for (int off = 0; off < 4; off += 2) begin
			h = 16'(32'hf00d7ab3 >> (16 - 8 * off));
			run_access("halfword_loads", lhz, base + 32'(off), 32'h0, rdata);
			check_value("halfword_loads", {16'h0, h}, rdata);
			run_access("halfword_loads", lhs, base + 32'(off), 32'h0, rdata);
			check_value("halfword_loads", {{16{h[15]}}, h}, rdata);
		end
		finish_test("halfword_loads", errs);
	endtask

	task automatic partial_stores();
		int          errs;
		logic [31:0] base;
		logic [31:0] rdata;
		errs      = error_count;
		base      = lfsr_bits(32);
		base[1:0] = 2'b00;
		run_access("partial_stores", sw, base, 32'h0, rdata);	// clean word
		for (int off = 0; off < 4; off++) begin
			run_access("partial_stores", sb, base + 32'(off), lfsr_bits(32), rdata);
			run_access("partial_stores", lwz, base, 32'h0, rdata);	// other lanes kept
		end
		for (int off = 0; off < 4; off += 2) begin
			run_access("partial_stores", sh, base + 32'(off), lfsr_bits(32), rdata);
			run_access("partial_stores", lwz, base, 32'h0, rdata);
		end
		finish_test("partial_stores", errs);
	endtask

	task automatic misaligned_access();
		int          errs;
		logic [31:0] base;
		logic [31:0] rdata;
		errs      = error_count;
		base      = lfsr_bits(32);
		base[1:0] = 2'b00;
		run_access("misaligned_access", sw, base, 32'h5eedc0de, rdata);
		for (int off = 1; off < 4; off++) begin
			run_access("misaligned_access", lwz, base + 32'(off), 32'h0, rdata);
			run_access("misaligned_access", sw, base + 32'(off), lfsr_bits(32), rdata);
			if (off != 2) begin
				run_access("misaligned_access", lhz, base + 32'(off), 32'h0, rdata);
				run_access("misaligned_access", lhs, base + 32'(off), 32'h0, rdata);
				run_access("misaligned_access", sh, base + 32'(off), lfsr_bits(32), rdata);
			end
		end
		run_access("misaligned_access", lwz, base, 32'h0, rdata);
		check_value("misaligned_access", 32'h5eedc0de, rdata);	// memory untouched
		finish_test("misaligned_access", errs);
	endtask

	task automatic pop_and_check();
		logic [31:0] exp_rdata;
		logic        exp_err;
		if (stream_rdata_q.size() == 0) begin
			error_count++;
			$display("stream_back_to_back: done pulse with no request in flight");
		end else begin
			exp_rdata = stream_rdata_q.pop_front();
			exp_err   = stream_err_q.pop_front();
			check_value("stream_back_to_back", exp_rdata, rsp.rdata);
			check_value("stream_back_to_back", {31'h0, exp_err}, {31'h0, rsp.align_err});
		end
	endtask

	task automatic stream_back_to_back();
		int          errs;
		int          cycles;
		lsu_op_e     op;
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] sel;
		logic [31:0] exp_rdata;
		logic        exp_err;
		errs = error_count;
		for (int i = 0; i < 64; i++) begin
			sel  = lfsr_bits(3);
			op   = pick_op(sel[2:0]);
			addr = lfsr_bits(6);	// 16 words for lots of reuse
			if (op == lhz || op == lhs || op == sh) begin
				addr[0] = 1'b0;
			end
			if (op == lwz || op == sw) begin
				addr[1:0] = 2'b00;
			end
			data = lfsr_bits(32);
			expected_response(op, addr, data, exp_rdata, exp_err);
			stream_rdata_q.push_back(exp_rdata);
			stream_err_q.push_back(exp_err);
			@(posedge clk);
			req      <= 1'b1;
			req_data <= '{op, addr, data};
			@(negedge clk);
			if (i > 0) begin
				check_value("stream_back_to_back", 32'h1, {31'h0, done});	// previous one answered
				if (done === 1'b1) begin
					pop_and_check();
				end
			end
		end
		@(posedge clk);
		req    <= 1'b0;
		cycles = 0;
		while (stream_rdata_q.size() > 0 && cycles < TIMEOUT) begin
			@(negedge clk);
			cycles++;
			if (done === 1'b1) begin
				pop_and_check();
			end
		end
		if (stream_rdata_q.size() > 0) begin
			error_count++;
			$display("stream_back_to_back: %0d requests got no done pulse", stream_rdata_q.size());
		end
		@(negedge clk);
		check_value("stream_back_to_back", 32'h0, {31'h0, done});	// pulse ends with the stream
		finish_test("stream_back_to_back", errs);
	endtask

	initial begin
		rst         = 1'b1;
		req         = 1'b0;
		req_data    = '{nop, 32'h0, 32'h0};
		lfsr_state  = 16'd20;	// seed
		error_count = 0;
		check_count = 0;
		test_count  = 0;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		reset_values();
		preload_memory();	// known contents before the tests
		word_round_trip();
		byte_loads();
		halfword_loads();
		partial_stores();
		misaligned_access();
		stream_back_to_back();
		$display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
		if (error_count == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* logic/lsu_top.sv */
`timescale 1ns/100ps

`include "lsu_settings.svh"

module lsu_top
	import lsu_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     req,	// request strobe from core
	input  lsu_req_t req_data,	// request payload
	output logic     done,	// response strobe
	output lsu_rsp_t rsp	// response payload
);

	mem_word_u                  st_data;	// store word on its lanes
	logic [3:0]                 st_be;	// store lane enables
	dmem_req_t                  mem_req;	// control to memory
	mem_word_u                  mem_rdata;	// registered read word
	lsu_op_e                    ld_op;	// load op in flight
	logic [1:0]                 ld_offset;	// its byte offset
	logic [`LSU_DATA_WIDTH-1:0] ld_data;	// extended load value

	lsu_ctrl i_lsu_ctrl (
		.clk       (clk),
		.rst       (rst),
		.req       (req),
		.req_data  (req_data),
		.st_data   (st_data),
		.st_be     (st_be),
		.ld_data   (ld_data),
		.mem_req   (mem_req),
		.ld_op     (ld_op),
		.ld_offset (ld_offset),
		.done      (done),
		.rsp       (rsp)
	);

	// store lane placement straight off the request
	lsu_reg2mem i_lsu_reg2mem (
		.op      (req_data.op),
		.offset  (req_data.addr[1:0]),
		.regdata (req_data.wdata),
		.memdata (st_data),
		.be      (st_be)
	);

	lsu_dmem i_lsu_dmem (
		.clk     (clk),
		.mem_req (mem_req),
		.rdata   (mem_rdata)
	);

	// extraction in the done cycle
	lsu_mem2reg i_lsu_mem2reg (
		.op      (ld_op),
		.offset  (ld_offset),
		.memdata (mem_rdata),
		.regdata (ld_data)
	);

endmodule

/* logic/lsu_ctrl.sv */
`timescale 1ns/100ps

`include "lsu_settings.svh"

module lsu_ctrl
	import lsu_pkg::*;
(
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       req,	// request strobe
	input  lsu_req_t                   req_data,	// op, address, store data
	input  mem_word_u                  st_data,	// lane placed store word
	input  logic [3:0]                 st_be,	// store lane enables
	input  logic [`LSU_DATA_WIDTH-1:0] ld_data,	// extended load value
	output dmem_req_t                  mem_req,	// to data memory
	output lsu_op_e                    ld_op,	// op of the load in flight
	output logic [1:0]                 ld_offset,	// its byte offset
	output logic                       done,	// one cycle after req
	output lsu_rsp_t                   rsp	// valid with done
);

	logic is_load;	// any load op
	logic is_store;	// any store op
	logic is_half;	// halfword access
	logic is_word;	// word access
	logic misalign;	// alignment check failed
	logic access;	// memory is touched this cycle

	logic    done_q;
	logic    align_err_q;
	logic    load_q;	// a load was issued last cycle
	lsu_op_e ld_op_q;	// op of the last request
	logic [1:0] ld_offset_q;

	// unknown codes decode as nop
	always_comb begin
		is_load  = 1'b0;
		is_store = 1'b0;
		is_half  = 1'b0;
		is_word  = 1'b0;
		case (req_data.op)
			lbz, lbs: begin
				is_load = 1'b1;	// bytes always aligned
			end
			lhz, lhs: begin
				is_load = 1'b1;
				is_half = 1'b1;
			end
			lwz: begin
				is_load = 1'b1;
				is_word = 1'b1;
			end
			sb: begin
				is_store = 1'b1;
			end
			sh: begin
				is_store = 1'b1;
				is_half  = 1'b1;
			end
			sw: begin
				is_store = 1'b1;
				is_word  = 1'b1;
			end
			default: begin
				is_load = 1'b0;	// nop
			end
		endcase
	end

	// natural alignment
	assign misalign = (is_half && req_data.addr[0]) ||
		(is_word && (req_data.addr[1:0] != 2'b00));

	// misaligned or nop never reaches memory
	assign access = req && (is_load || is_store) && !misalign;

	// word address aliases above the memory depth
	always_comb begin
		mem_req.en    = access;
		mem_req.we    = is_store;
		mem_req.be    = st_be;
		mem_req.waddr = req_data.addr[`LSU_MEM_AW+1:2];
		mem_req.wdata = st_data;
	end

	// response control
	always_ff @(posedge clk) begin
		if (rst) begin
			done_q      <= 1'b0;
			align_err_q <= 1'b0;
			load_q      <= 1'b0;
		end else begin
			done_q      <= req;	// fixed one cycle latency
			align_err_q <= req && misalign;
			load_q      <= access && is_load;
		end
	end

	// load info for the extraction stage
	always_ff @(posedge clk) begin
		if (req) begin
			ld_op_q     <= req_data.op;
			ld_offset_q <= req_data.addr[1:0];
		end
	end

	assign ld_op     = ld_op_q;
	assign ld_offset = ld_offset_q;
	assign done      = done_q;

	// zero data on stores, nops and errors
	always_comb begin
		rsp.rdata     = load_q ? ld_data : '0;
		rsp.align_err = align_err_q;
	end

endmodule

/* logic/lsu_dmem.sv */
`timescale 1ns/100ps

`include "lsu_settings.svh"

module lsu_dmem
	import lsu_pkg::*;
(
	input  logic      clk,
	input  dmem_req_t mem_req,	// port from control
	output mem_word_u rdata	// registered read word
);

	mem_word_u mem [`LSU_MEM_WORDS];	// word storage

	// byte lane writes
	always_ff @(posedge clk) begin
		if (mem_req.en && mem_req.we) begin
			for (int i = 0; i < 4; i++) begin
				if (mem_req.be[i]) begin
					mem[mem_req.waddr].bytes[i] <= mem_req.wdata.bytes[i];	// only enabled lanes
				end
			end
		end
	end

	// synchronous read with data valid next cycle
	always_ff @(posedge clk) begin
		if (mem_req.en && !mem_req.we) begin
			rdata <= mem[mem_req.waddr];	// holds on writes and idle
		end
	end

endmodule

/* logic/lsu_reg2mem.sv */
`timescale 1ns/100ps

`include "lsu_settings.svh"

module lsu_reg2mem
	import lsu_pkg::*;
(
	input  lsu_op_e                    op,	// request op
	input  logic [1:0]                 offset,	// byte offset in word
	input  logic [`LSU_DATA_WIDTH-1:0] regdata,	// store value, low aligned
	output mem_word_u                  memdata,	// lane placed word
	output logic [3:0]                 be	// lane enables
);

	logic [1:0] byte_lane;	// lane for sb
	logic [1:0] hi_lane;	// upper lane for sh
	logic [1:0] lo_lane;	// lower lane for sh

	// big endian lane numbering
	assign byte_lane = ~offset;
	assign hi_lane   = {~offset[1], 1'b1};
	assign lo_lane   = {~offset[1], 1'b0};

	always_comb begin
		memdata.word = '0;	// unused lanes stay zero
		be           = 4'b0000;	// no write by default
		case (op)
			sb: begin
				memdata.bytes[byte_lane] = regdata[7:0];	// low byte to its lane
				be[byte_lane]            = 1'b1;
			end
			sh: begin
				memdata.bytes[hi_lane] = regdata[15:8];	// msb half of value
				memdata.bytes[lo_lane] = regdata[7:0];
				be[hi_lane]            = 1'b1;
				be[lo_lane]            = 1'b1;
			end
			sw: begin
				memdata.word = regdata;	// all lanes
				be           = 4'b1111;
			end
			default: begin
				be = 4'b0000;	// loads and nop write nothing
			end
		endcase
	end

endmodule

/* logic/lsu_mem2reg.sv */
`timescale 1ns/100ps

`include "lsu_settings.svh"

module lsu_mem2reg
	import lsu_pkg::*;
(
	input  lsu_op_e                    op,	// registered load op
	input  logic [1:0]                 offset,	// byte offset in word
	input  mem_word_u                  memdata,	// word from memory
	output logic [`LSU_DATA_WIDTH-1:0] regdata	// value for the register file
);

	logic [7:0]  byte_sel;	// addressed byte
	logic [15:0] half_sel;	// addressed halfword

	// big endian lanes, offset 0 is the msb lane
	always_comb begin
		byte_sel = memdata.bytes[~offset];	// lane 3 - offset
	end

	// halfword at offset 0 sits in lanes 3/2, offset 2 in lanes 1/0
	always_comb begin
		half_sel = {memdata.bytes[{~offset[1], 1'b1}],	// upper lane
			memdata.bytes[{~offset[1], 1'b0}]};	// lower lane
	end

	// extension per op
	always_comb begin
		case (op)
			lbz: begin
				regdata = {{(`LSU_DATA_WIDTH-8){1'b0}}, byte_sel};	// zero fill
			end
			lbs: begin
				regdata = {{(`LSU_DATA_WIDTH-8){byte_sel[7]}}, byte_sel};	// sign fill
			end
			lhz: begin
				regdata = {{(`LSU_DATA_WIDTH-16){1'b0}}, half_sel};	// zero fill
			end
			lhs: begin
				regdata = {{(`LSU_DATA_WIDTH-16){half_sel[15]}}, half_sel};	// sign fill
			end
			default: begin
				regdata = memdata.word;	// lwz, whole word
			end
		endcase
	end

endmodule

/* logic/lsu_pkg.sv */
`include "lsu_settings.svh"

package lsu_pkg;

	// lsu operation codes, bit 3 set on stores
	typedef enum logic [3:0] {
		nop = 4'b0000,	// no access
		lbz = 4'b0010,	// byte, zero ext
		lbs = 4'b0011,	// byte, sign ext
		lhz = 4'b0100,	// halfword, zero ext
		lhs = 4'b0101,	// halfword, sign ext
		lwz = 4'b0110,	// full word
		sb  = 4'b1010,	// store byte
		sh  = 4'b1100,	// store halfword
		sw  = 4'b1110	// store word
	} lsu_op_e;

	// request from the core
	typedef struct packed {
		lsu_op_e                    op;	// operation
		logic [31:0]                addr;	// byte address
		logic [`LSU_DATA_WIDTH-1:0] wdata;	// store data, low aligned
	} lsu_req_t;

	// response back to the core
	typedef struct packed {
		logic [`LSU_DATA_WIDTH-1:0] rdata;	// extended load data
		logic                       align_err;	// misaligned access flag
	} lsu_rsp_t;

	// one memory word, whole or per byte lane
	// lane 3 is the top byte, addressed by offset 0
	typedef union packed {
		logic [`LSU_DATA_WIDTH-1:0]        word;	// whole word
		logic [`LSU_DATA_WIDTH/8-1:0][7:0] bytes;	// byte lanes
	} mem_word_u;

	// data memory port
	typedef struct packed {
		logic                   en;	// access this cycle
		logic                   we;	// write, else read
		logic [3:0]             be;	// lane enables
		logic [`LSU_MEM_AW-1:0] waddr;	// word address
		mem_word_u              wdata;	// lane aligned store data
	} dmem_req_t;

endpackage

/* logic/lsu_settings.svh */
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// data path width, one cpu word
`define LSU_DATA_WIDTH 32

// data memory depth in words
`define LSU_MEM_WORDS 256

// word address bits, log2 of the depth
`define LSU_MEM_AW 8

`endif
